// File: frame_ring_engine.f
logic/frame_ring_pkg.sv
logic/frame_reader.sv
logic/frame_release.sv
logic/request_arbiter.sv
logic/request_queue.sv
logic/frame_ring_engine.sv
verification/frame_ring_engine_tb.sv

// File: logic/frame_reader.sv
// Frame reader
// Turns frame tokens into chunk read requests

`timescale 1ns/1ps

module frame_reader #(
   parameter int LOG_FRAME_NUMBER       = 3,
   parameter int LOG_FRAME_CHUNKS       = 2,
   parameter int LOG_FRAME_BASE_POINTER = 10
) (
   input  logic                              clk,
   input  logic                              resetb,

   // Token handshake from the producer
   input  logic                              frame_valid,
   output logic                              frame_ready,
   input  logic [LOG_FRAME_BASE_POINTER-1:0] frame_base_pointer,

   // Request side towards the arbiter
   input  frame_ring_pkg::arb_grant_t        grant,
   output logic                              rd_request,
   output frame_ring_pkg::mem_req_t          rd_req,

   // Pulse to the release block once a frame has been fully read
   output logic                              release_frame
);

   import frame_ring_pkg::*;

   // Index of the final chunk of a frame
   localparam logic [LOG_FRAME_CHUNKS-1:0] LAST_CHUNK = '1;

   // Set while a frame is being read
   logic                        busy;
   // Frame currently read, advancing in ring order
   logic [LOG_FRAME_NUMBER-1:0] frame_number;
   // Chunk whose read is being requested
   logic [LOG_FRAME_CHUNKS-1:0] chunk;
   // Token accepted on this edge
   logic                        accept;
   // Grant for the final chunk of the current frame
   logic                        last_grant;

   // Ready only while no frame is held
   assign frame_ready = !busy;
   assign accept      = frame_valid && frame_ready;

   // The request is held high until the arbiter takes it
   assign rd_request  = busy;
   assign last_grant  = grant.reader_grant && (chunk == LAST_CHUNK);

   always_ff @(posedge clk) begin
      if (!resetb) begin
         busy          <= 1'b0;
         frame_number  <= '0;
         chunk         <= '0;
         release_frame <= 1'b0;
      end else begin
         // Release is a single-cycle pulse
         release_frame <= 1'b0;

         if (accept) begin
            // Chunk 0 is requested from the next cycle on
            busy <= 1'b1;
         end

         if (grant.reader_grant) begin
            if (last_grant) begin
               // Frame done, so wrap the chunk and move to the next frame
               chunk         <= '0;
               frame_number  <= frame_number + 1'b1;
               busy          <= 1'b0;
               release_frame <= 1'b1;
            end else begin
               chunk <= chunk + 1'b1;
            end
         end
      end
   end

   // Payload for the current chunk read
   // It stays stable while the request waits for a grant, since the
   // frame and chunk counters only move on a grant
   always_comb begin
      rd_req      = '0;
      rd_req.kind = RD_LINE;
      rd_req.addr = line_addr(ADDR_WIDTH'(frame_base_pointer),
                              ADDR_WIDTH'(frame_number),
                              ADDR_WIDTH'(chunk),
                              LOG_FRAME_NUMBER,
                              LOG_FRAME_CHUNKS);
   end

endmodule

// File: logic/frame_release.sv
// Frame release
// Clears frame header lines once frames are read

`timescale 1ns/1ps

module frame_release #(
   parameter int LOG_FRAME_NUMBER       = 3,
   parameter int LOG_FRAME_CHUNKS       = 2,
   parameter int LOG_FRAME_BASE_POINTER = 10
) (
   input  logic                              clk,
   input  logic                              resetb,
   input  logic [LOG_FRAME_BASE_POINTER-1:0] frame_base_pointer,

   // One pulse per fully read frame
   input  logic                              release_frame,

   // Request side towards the arbiter
   input  frame_ring_pkg::arb_grant_t        grant,
   output logic                              wr_request,
   output frame_ring_pkg::mem_req_t          wr_req
);

   import frame_ring_pkg::*;

   // Frames waiting to be cleared
   // One extra bit so a completely full ring can be counted
   logic [LOG_FRAME_NUMBER:0]   frames_to_clear;
   logic [LOG_FRAME_NUMBER:0]   frames_to_clear_next;
   // Oldest frame not yet cleared
   logic [LOG_FRAME_NUMBER-1:0] frame_number_clear;

   // Request as long as anything is left to clear
   assign wr_request = (frames_to_clear != '0);

   // A release and a grant may land in the same cycle and cancel out
   always_comb begin
      frames_to_clear_next = frames_to_clear;
      if (release_frame) begin
         frames_to_clear_next = frames_to_clear_next + 1'b1;
      end
      if (grant.release_grant) begin
         frames_to_clear_next = frames_to_clear_next - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         frames_to_clear    <= '0;
         frame_number_clear <= '0;
      end else begin
         frames_to_clear <= frames_to_clear_next;
         // Each granted clear moves on to the next frame of the ring
         if (grant.release_grant) begin
            frame_number_clear <= frame_number_clear + 1'b1;
         end
      end
   end

   // Header line is chunk 0 of the frame
   always_comb begin
      wr_req      = '0;
      wr_req.kind = WR_LINE;
      wr_req.addr = line_addr(ADDR_WIDTH'(frame_base_pointer),
                              ADDR_WIDTH'(frame_number_clear),
                              '0,
                              LOG_FRAME_NUMBER,
                              LOG_FRAME_CHUNKS);
   end

endmodule

// File: logic/frame_ring_engine.sv
// Frame ring engine top level

`timescale 1ns/1ps

module frame_ring_engine #(
   parameter int LOG_FRAME_NUMBER       = frame_ring_pkg::DEF_LOG_FRAME_NUMBER,
   parameter int LOG_FRAME_CHUNKS       = frame_ring_pkg::DEF_LOG_FRAME_CHUNKS,
   parameter int LOG_FRAME_BASE_POINTER = frame_ring_pkg::DEF_LOG_FRAME_BASE_POINTER
) (
   input  logic                              clk,
   input  logic                              resetb,

   // Frame tokens from the producer
   input  logic                              frame_valid,
   output logic                              frame_ready,
   input  logic [LOG_FRAME_BASE_POINTER-1:0] frame_base_pointer,

   // Memory request port
   output logic                              req_valid,
   output frame_ring_pkg::mem_req_t          req,
   input  logic                              req_ready
);

   import frame_ring_pkg::*;

   // Requests from the two processing blocks
   logic       rd_request;
   logic       wr_request;
   mem_req_t   rd_req;
   mem_req_t   wr_req;
   arb_grant_t grant;
   // Reader to release handoff
   logic       release_frame;
   // Arbiter to queue
   logic       enq_valid;
   logic       enq_ready;
   mem_req_t   enq_req;

   // Reads every chunk of each handed-over frame
   frame_reader #(
      .LOG_FRAME_NUMBER       (LOG_FRAME_NUMBER),
      .LOG_FRAME_CHUNKS       (LOG_FRAME_CHUNKS),
      .LOG_FRAME_BASE_POINTER (LOG_FRAME_BASE_POINTER)
   ) frame_reader_inst (
      .clk                (clk),
      .resetb             (resetb),
      .frame_valid        (frame_valid),
      .frame_ready        (frame_ready),
      .frame_base_pointer (frame_base_pointer),
      .grant              (grant),
      .rd_request         (rd_request),
      .rd_req             (rd_req),
      .release_frame      (release_frame)
   );

   // Clears the header line of each frame after its reads
   frame_release #(
      .LOG_FRAME_NUMBER       (LOG_FRAME_NUMBER),
      .LOG_FRAME_CHUNKS       (LOG_FRAME_CHUNKS),
      .LOG_FRAME_BASE_POINTER (LOG_FRAME_BASE_POINTER)
   ) frame_release_inst (
      .clk                (clk),
      .resetb             (resetb),
      .frame_base_pointer (frame_base_pointer),
      .release_frame      (release_frame),
      .grant              (grant),
      .wr_request         (wr_request),
      .wr_req             (wr_req)
   );

   request_arbiter request_arbiter_inst (
      .clk        (clk),
      .resetb     (resetb),
      .rd_request (rd_request),
      .wr_request (wr_request),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .enq_ready  (enq_ready),
      .grant      (grant),
      .enq_valid  (enq_valid),
      .enq_req    (enq_req)
   );

   // Decouples the grants from external back-pressure
   request_queue request_queue_inst (
      .clk       (clk),
      .resetb    (resetb),
      .enq_valid (enq_valid),
      .enq_req   (enq_req),
      .enq_ready (enq_ready),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready)
   );

endmodule

// File: logic/frame_ring_pkg.sv
// Frame ring engine shared types
// Request kinds, request payloads and ring geometry

package frame_ring_pkg;

   // Width of a cache-line address on the memory request port
   parameter int ADDR_WIDTH = 32;

   // Default ring geometry, used by the top level as parameter defaults
   // Eight frames of four chunks each, placed under a 10-bit base pointer
   parameter int DEF_LOG_FRAME_NUMBER = 3;
   parameter int DEF_LOG_FRAME_CHUNKS = 2;
   parameter int DEF_LOG_FRAME_BASE_POINTER = 10;

   // Kind of a memory request
   // A write always carries an all-zero line, so no data travels with it
   typedef enum logic {
      RD_LINE = 1'b0,
      WR_LINE = 1'b1
   } req_kind_e;

   // One request on the memory port, 33 bits in all
   typedef struct packed {
      req_kind_e               kind;
      logic [ADDR_WIDTH-1:0]   addr;
   } mem_req_t;

   // Grants returned by the arbiter to the two requesters
   // Each bit is a one-cycle pulse, and the requester advances on that edge
   typedef struct packed {
      logic reader_grant;
      logic release_grant;
   } arb_grant_t;

   // Builds a cache-line address from base pointer, frame and chunk
   // The fields are packed from the top down as {base, frame, chunk}
   // Callers pass each field zero-extended to ADDR_WIDTH together with
   // the widths of the frame and chunk fields
   function automatic logic [ADDR_WIDTH-1:0] line_addr(
      input logic [ADDR_WIDTH-1:0] base,
      input logic [ADDR_WIDTH-1:0] frame,
      input logic [ADDR_WIDTH-1:0] chunk,
      input int unsigned           frame_bits,
      input int unsigned           chunk_bits
   );
      logic [ADDR_WIDTH-1:0] addr;
      addr = base << (frame_bits + chunk_bits);
      // Frame number sits just above the chunk field
      addr = addr | (frame << chunk_bits);
      // Chunk number fills the lowest bits
      addr = addr | chunk;
      return addr;
   endfunction

endpackage

// File: logic/request_arbiter.sv
// Request arbiter
// Round-robin choice between reads and clears

`timescale 1ns/1ps

module request_arbiter (
   input  logic                       clk,
   input  logic                       resetb,

   // Requesters
   input  logic                       rd_request,
   input  logic                       wr_request,
   input  frame_ring_pkg::mem_req_t   rd_req,
   input  frame_ring_pkg::mem_req_t   wr_req,

   // Room in the output queue
   input  logic                       enq_ready,

   // Grants back to the requesters
   output frame_ring_pkg::arb_grant_t grant,

   // Write side of the output queue
   output logic                       enq_valid,
   output frame_ring_pkg::mem_req_t   enq_req
);

   import frame_ring_pkg::*;

   // High when the release block won the last granted cycle
   logic last_release;
   // Release block wins this cycle
   logic pick_release;

   // With both asking, the one not granted most recently wins
   // A lone requester always wins
   assign pick_release = wr_request && (!rd_request || !last_release);

   // Grants only go out when the queue can take the entry
   always_comb begin
      grant               = '0;
      grant.release_grant = enq_ready && pick_release;
      grant.reader_grant  = enq_ready && rd_request && !pick_release;
   end

   // The queue writes on enq_valid with enq_ready, which matches the grants
   assign enq_valid = rd_request || wr_request;
   assign enq_req   = pick_release ? wr_req : rd_req;

   // Remember the winner only when something was actually granted
   always_ff @(posedge clk) begin
      if (!resetb) begin
         last_release <= 1'b0;
      end else begin
         if (grant.release_grant) begin
            last_release <= 1'b1;
         end else if (grant.reader_grant) begin
            last_release <= 1'b0;
         end
      end
   end

endmodule

// File: logic/request_queue.sv
// Request queue
// Two-entry buffer in front of the memory port

`timescale 1ns/1ps

module request_queue (
   input  logic                     clk,
   input  logic                     resetb,

   // Write side from the arbiter
   input  logic                     enq_valid,
   input  frame_ring_pkg::mem_req_t enq_req,
   output logic                     enq_ready,

   // External request port
   output logic                     req_valid,
   output frame_ring_pkg::mem_req_t req,
   input  logic                     req_ready
);

   import frame_ring_pkg::*;

   // Storage for the two entries
   mem_req_t   entries [2];
   logic       rd_ptr;
   logic       wr_ptr;
   // Number of occupied entries, 0 to 2
   logic [1:0] count;
   logic       do_enq;
   logic       do_deq;

   // Room exists as long as one slot is free
   // Taken from the count alone, so req_ready has no path to the arbiter
   assign enq_ready = (count != 2'd2);
   assign do_enq    = enq_valid && enq_ready;

   // The head entry is offered as soon as it is written
   assign req_valid = (count != 2'd0);
   assign req       = entries[rd_ptr];
   assign do_deq    = req_valid && req_ready;

   // Payload storage
   always_ff @(posedge clk) begin
      if (do_enq) begin
         entries[wr_ptr] <= enq_req;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         rd_ptr <= 1'b0;
         wr_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (do_enq) begin
            wr_ptr <= !wr_ptr;
         end
         if (do_deq) begin
            rd_ptr <= !rd_ptr;
         end
         // Simultaneous enqueue and dequeue leave the count unchanged
         if (do_enq && !do_deq) begin
            count <= count + 2'd1;
         end else if (do_deq && !do_enq) begin
            count <= count - 2'd1;
         end
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the frame ring engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module frame_ring_engine_tb \
   -Mdir obj_dir \
   -f frame_ring_engine.f \
   || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vframe_ring_engine_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Simulation PASSED" \
   && exit 0 \
   || exit 1

// File: verification/frame_ring_engine_tb.sv
// Frame ring engine testbench
// Trace-driven with random back-pressure

`timescale 1ns/1ps

module frame_ring_engine_tb;

   import frame_ring_pkg::*;

   // Default ring geometry as used by the DUT instance
   localparam int FN_BITS   = DEF_LOG_FRAME_NUMBER;
   localparam int CH_BITS   = DEF_LOG_FRAME_CHUNKS;
   localparam int BP_BITS   = DEF_LOG_FRAME_BASE_POINTER;
   localparam int FRAMES    = 1 << FN_BITS;
   localparam int CHUNKS    = 1 << CH_BITS;
   localparam int MAX_TESTS = 32;

   logic               clk = 1'b0;
   logic               resetb;
   logic               frame_valid;
   logic               frame_ready;
   logic [BP_BITS-1:0] frame_base_pointer;
   logic               req_valid;
   mem_req_t           req;
   logic               req_ready = 1'b0;

   // Three words per test holding base pointer, frame count and stall percent
   logic [31:0] trace_mem [0:3*MAX_TESTS-1];

   integer seed            = 32'h811c;
   int     stall_pct       = 0;
   int     watchdog_cycles = 0;
   int     error_count     = 0;
   // Checker state kept by the monitor block
   int     tokens_taken    = 0;
   int     reads_seen      = 0;
   int     xfer_count      = 0;
   int     exp_frame       = 0;
   int     exp_chunk       = 0;
   // Frames whose reads are complete and whose clear is still due
   int     clear_q[$];

   frame_ring_engine frame_ring_engine_inst (
      .clk                (clk),
      .resetb             (resetb),
      .frame_valid        (frame_valid),
      .frame_ready        (frame_ready),
      .frame_base_pointer (frame_base_pointer),
      .req_valid          (req_valid),
      .req                (req),
      .req_ready          (req_ready)
   );

   always #50 clk = ~clk;

   // The port is held off for roughly stall_pct percent of cycles
   always @(posedge clk) begin
      req_ready <= (({$random(seed)} % 100) >= stall_pct);
   end

   // Line address is {base, frame, chunk} zero-extended to 32 bits
   function automatic logic [31:0] expected_addr(input logic [BP_BITS-1:0] base,
                                                 input int frame,
                                                 input int chunk);
      logic [31:0] addr;
      logic [FN_BITS-1:0] f;
      logic [CH_BITS-1:0] c;
      f    = frame[FN_BITS-1:0];
      c    = chunk[CH_BITS-1:0];
      addr = '0;
      addr[BP_BITS+FN_BITS+CH_BITS-1:0] = {base, f, c};
      return addr;
   endfunction

   task automatic check_transfer();
      logic [31:0] want;
      int frame;
      if (req.kind == RD_LINE) begin
         assert (reads_seen < tokens_taken * CHUNKS) else begin
            $display("[FAIL] %0t: read request with no frame token outstanding", $time);
            error_count++;
         end
         want = expected_addr(frame_base_pointer, exp_frame, exp_chunk);
         assert (req.addr == want) else begin
            $display("[FAIL] %0t: read of frame %0d chunk %0d at %h, expected %h",
                     $time, exp_frame, exp_chunk, req.addr, want);
            error_count++;
         end
         reads_seen++;
         // The last chunk completes the frame, which is then due for clearing
         if (exp_chunk == CHUNKS - 1) begin
            clear_q.push_back(exp_frame);
            exp_chunk = 0;
            exp_frame = (exp_frame + 1) % FRAMES;
         end else begin
            exp_chunk++;
         end
      end else begin
         assert (clear_q.size() > 0) else begin
            $display("[FAIL] %0t: clear write at %h before any frame was fully read",
                     $time, req.addr);
            error_count++;
         end
         if (clear_q.size() > 0) begin
            frame = clear_q.pop_front();
            want  = expected_addr(frame_base_pointer, frame, 0);
            assert (req.addr == want) else begin
               $display("[FAIL] %0t: clear of frame %0d at %h, expected %h",
                        $time, frame, req.addr, want);
               error_count++;
            end
         end
      end
      xfer_count++;
   endtask

   // Monitor for tokens and request transfers
   always @(posedge clk) begin
      if (resetb) begin
         // Until the first token the engine must stay idle and ready
         if (tokens_taken == 0) begin
            assert (frame_ready && !req_valid) else begin
               $display("[FAIL] %0t: not idle before first token, frame_ready %b req_valid %b",
                        $time, frame_ready, req_valid);
               error_count++;
            end
         end
         if (req_valid && req_ready) begin
            check_transfer();
         end
         if (frame_valid && frame_ready) begin
            tokens_taken++;
         end
      end
   end

   initial begin
      int n_tests;
      int total_frames;
      int target;
      int errors_before;
      int tests_failed;
      int sent;
      int frames;
      resetb             = 1'b0;
      frame_valid        = 1'b0;
      frame_base_pointer = '0;
      // Each unfilled word holds the inverse of its own index
      for (int i = 0; i < 3 * MAX_TESTS; i++) begin
         trace_mem[i] = ~32'(i);
      end
      $readmemh("verification/frame_ring_trace.txt", trace_mem);
      n_tests      = 0;
      total_frames = 0;
      // Unfilled words keep all ones in their upper half and end the list
      while (n_tests < MAX_TESTS && trace_mem[3*n_tests+1][31:16] != 16'hffff) begin
         total_frames += int'(trace_mem[3*n_tests+1]);
         n_tests++;
      end
      watchdog_cycles = total_frames * (CHUNKS + 1) * 20 + 100;

      repeat (2) @(posedge clk);
      resetb <= 1'b1;
      // Idle stretch with no token while the monitor watches the port
      repeat (10) @(posedge clk);
      @(negedge clk);
      tests_failed = (error_count != 0) ? 1 : 0;
      $display("Test 0: reset state, %s", (error_count == 0) ? "passed" : "failed");

      target = 0;
      for (int t = 0; t < n_tests; t++) begin
         @(negedge clk);
         errors_before = error_count;
         frames        = int'(trace_mem[3*t+1]);
         target        += frames * (CHUNKS + 1);
         @(posedge clk);
         frame_base_pointer <= trace_mem[3*t][BP_BITS-1:0];
         stall_pct          <= int'(trace_mem[3*t+2]);
         // Offer tokens whenever the reader is free
         sent = 0;
         while (sent < frames) begin
            @(posedge clk);
            if (frame_valid && frame_ready) begin
               sent++;
            end
            frame_valid <= (sent < frames);
         end
         // All reads and clears of this test drain before the base moves
         while (xfer_count < target) begin
            @(negedge clk);
         end
         if (error_count != errors_before) begin
            tests_failed++;
         end
         $display("Test %0d: base %h, %0d frames, %0d%% stall, %s", t + 1,
                  trace_mem[3*t][BP_BITS-1:0], frames, int'(trace_mem[3*t+2]),
                  (error_count == errors_before) ? "passed" : "failed");
      end

      // Nothing further may appear once the ring has drained
      repeat (10) @(posedge clk);
      @(negedge clk);
      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               n_tests + 1, n_tests + 1 - tests_failed, tests_failed, error_count);
      if (n_tests == 0) begin
         $display("The trace file held no tests");
      end
      if (error_count == 0 && tests_failed == 0 && n_tests > 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog sized from the trace once it is loaded
   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout after %0d cycles, the engine stopped issuing requests",
               watchdog_cycles);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: verification/frame_ring_trace.txt
// Frame ring engine trace, one test per line, all values in hex
// base pointer, frame count, req_ready stall percent
000 01 00   // single frame
3ff 01 00
12a 05 00
2d5 06 00   // frame number wraps from 7 to 0
0f0 08 00
155 03 0a   // 10 percent
2aa 04 19   // 25 percent
3c3 07 32   // 50 percent
081 09 14
1e7 02 4b   // 75 percent
300 0a 28
0ff 05 3c
246 0c 1e
379 06 46
050 04 00
11d 08 32
